//--- rvMultiCycle.f
logic/rvCorePkg.sv
logic/alu.sv
logic/regFile.sv
logic/immGen.sv
logic/controlUnit.sv
logic/datapath.sv
logic/rvMultiCycle.sv
bench/rvChecker.sv
bench/rvMultiCycleTb.sv

//--- Bender.yml
package:
  name: rvMultiCycle

sources:
  - files:
      - logic/rvCorePkg.sv
      - logic/alu.sv
      - logic/regFile.sv
      - logic/immGen.sv
      - logic/controlUnit.sv
      - logic/datapath.sv
      - logic/rvMultiCycle.sv
  - target: test
    files:
      - bench/rvChecker.sv
      - bench/rvMultiCycleTb.sv

//--- bench/rvMultiCycleTb.sv
//####################
// testbench for the multicycle rv32i core
// memory with random ack delay, program table, watchdog
//####################
`timescale 1ns/1ps
`default_nettype none

module rvMultiCycleTb;

    localparam int          maxRows     = 64;
    localparam int          maxDelay    = 3;
    localparam int          resetCycles = 10;
    localparam logic [31:0] dataBase    = 32'h200; // x10 points here
    localparam logic [6:0]  opImm       = 7'h13;
    localparam logic [6:0]  opLoad      = 7'h03;
    localparam logic [6:0]  opJalr      = 7'h67;
    localparam logic [6:0]  opLui       = 7'h37;
    localparam logic [6:0]  opAuipc     = 7'h17;

    logic        clk;
    logic        arstN;
    logic        memReq;
    logic        memWe;
    logic [31:0] memAddr;
    logic [31:0] memWdata;
    logic        memAck;
    logic [31:0] memRdata;

    logic [31:0] mem      [0:255];
    logic [31:0] rowInstr [0:maxRows-1];
    logic        rowStore [0:maxRows-1];
    logic [31:0] rowAddr  [0:maxRows-1];
    logic [31:0] rowData  [0:maxRows-1];
    int          rowCount;
    logic [31:0] haltAddr;
    int          haltFetches;
    int          limitCycles;
    logic [31:0] lfsr;
    logic [1:0]  waitLeft;
    logic        waitActive;

    rvMultiCycle #(
        .resetPc (32'h0)
    ) uut (
        .clk      (clk),
        .arstN    (arstN),
        .memReq   (memReq),
        .memWe    (memWe),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .memAck   (memAck),
        .memRdata (memRdata)
    );

    rvChecker #(
        .maxStores (maxRows)
    ) storeCheck (
        .clk      (clk),
        .arstN    (arstN),
        .memReq   (memReq),
        .memWe    (memWe),
        .memAck   (memAck),
        .memAddr  (memAddr),
        .memWdata (memWdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32, 22, 2, 1
    endfunction

    function automatic logic [31:0] encodeR(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] encodeI(input logic [6:0] op, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encodeS(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23}; // sw only
    endfunction

    function automatic logic [31:0] encodeB(input logic [2:0] f3, input logic [4:0] rs1,
                                            input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] encodeU(input logic [6:0] op, input logic [4:0] rd,
                                            input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] encodeJ(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    task automatic addInstr(input logic [31:0] instr);
        rowInstr[rowCount] = instr;
        rowStore[rowCount] = 1'b0;
        rowCount++;
    endtask

    // sw rs2, off(x10) with the value it must write
    task automatic addStore(input logic [4:0] rs2, input logic [11:0] off,
                            input logic [31:0] data);
        rowInstr[rowCount] = encodeS(rs2, 5'd10, off);
        rowStore[rowCount] = 1'b1;
        rowAddr[rowCount]  = dataBase + off;
        rowData[rowCount]  = data;
        rowCount++;
    endtask

    task automatic buildProgram();
        addInstr(encodeI(opImm, 3'b000, 5'd10, 5'd0, 12'd512)); // addi x10, x0, 0x200
        addInstr(encodeI(opImm, 3'b000, 5'd1, 5'd0, 12'd12));   // x1 = 12
        addInstr(encodeI(opImm, 3'b000, 5'd2, 5'd0, 12'hffb));  // x2 = -5
        addInstr(32'h0000_0000); // unknown opcode, skipped
        addInstr(encodeR(7'h00, 3'b000, 5'd3, 5'd1, 5'd2)); // add
        addStore(5'd3, 12'd0, 32'h0000_0007);
        addInstr(encodeR(7'h20, 3'b000, 5'd3, 5'd1, 5'd2)); // sub
        addStore(5'd3, 12'd4, 32'h0000_0011);
        addInstr(encodeR(7'h00, 3'b111, 5'd3, 5'd1, 5'd2)); // and
        addStore(5'd3, 12'd8, 32'h0000_0008);
        addInstr(encodeR(7'h00, 3'b110, 5'd3, 5'd1, 5'd2)); // or
        addStore(5'd3, 12'd12, 32'hffff_ffff);
        addInstr(encodeR(7'h00, 3'b100, 5'd3, 5'd1, 5'd2)); // xor
        addStore(5'd3, 12'd16, 32'hffff_fff7);
        addInstr(encodeR(7'h00, 3'b010, 5'd3, 5'd2, 5'd1)); // slt -5 < 12
        addStore(5'd3, 12'd20, 32'h0000_0001);
        addInstr(encodeR(7'h00, 3'b001, 5'd3, 5'd2, 5'd1)); // sll by 12
        addStore(5'd3, 12'd24, 32'hffff_b000);
        addInstr(encodeR(7'h00, 3'b101, 5'd3, 5'd2, 5'd1)); // srl by 12
        addStore(5'd3, 12'd28, 32'h000f_ffff);
        addInstr(encodeI(opImm, 3'b111, 5'd3, 5'd2, 12'h0f0)); // andi
        addStore(5'd3, 12'd32, 32'h0000_00f0);
        addInstr(encodeI(opImm, 3'b110, 5'd3, 5'd1, 12'hf00)); // ori, imm -256
        addStore(5'd3, 12'd36, 32'hffff_ff0c);
        addInstr(encodeI(opImm, 3'b100, 5'd3, 5'd1, 12'h7ff)); // xori
        addStore(5'd3, 12'd40, 32'h0000_07f3);
        addInstr(encodeI(opImm, 3'b010, 5'd3, 5'd1, 12'd5));  // slti 12 < 5
        addStore(5'd3, 12'd44, 32'h0000_0000);
        addInstr(encodeI(opLoad, 3'b010, 5'd4, 5'd10, 12'd4)); // lw x4, 4(x10)
        addStore(5'd4, 12'd48, 32'h0000_0011);
        addInstr(encodeB(3'b000, 5'd1, 5'd1, 13'd8)); // beq taken
        addInstr(encodeS(5'd0, 5'd10, 12'd52));
        addInstr(encodeB(3'b001, 5'd1, 5'd2, 13'd8)); // bne taken
        addInstr(encodeS(5'd0, 5'd10, 12'd52));
        addInstr(encodeB(3'b000, 5'd1, 5'd2, 13'd8)); // beq falls through
        addStore(5'd1, 12'd52, 32'h0000_000c);
        addInstr(encodeB(3'b001, 5'd1, 5'd1, 13'd8)); // bne falls through
        addStore(5'd2, 12'd56, 32'hffff_fffb);
        addInstr(encodeU(opLui, 5'd5, 20'h12345));
        addStore(5'd5, 12'd60, 32'h1234_5000);
        addInstr(encodeU(opAuipc, 5'd6, 20'h00001)); // at 0xa0
        addStore(5'd6, 12'd64, 32'h0000_10a0);
        addInstr(encodeJ(5'd7, 21'd8)); // jal at 0xa8
        addInstr(encodeS(5'd0, 5'd10, 12'd68));
        addStore(5'd7, 12'd68, 32'h0000_00ac);
        addInstr(encodeI(opImm, 3'b000, 5'd8, 5'd0, 12'h0bd));
        addInstr(encodeI(opJalr, 3'b000, 5'd9, 5'd8, 12'd4)); // 0xc1 lands on 0xc0
        addInstr(encodeS(5'd0, 5'd10, 12'd72));
        addStore(5'd9, 12'd72, 32'h0000_00bc);
        addInstr(encodeJ(5'd0, 21'd0)); // jump to itself
    endtask

    task automatic loadProgram();
        for (int i = 0; i < 256; i++)
            mem[i] = {8'hc3, i[7:0], 8'h3c, ~i[7:0]};
        for (int r = 0; r < rowCount; r++)
        begin
            mem[r] = rowInstr[r];
            if (rowStore[r])
                storeCheck.addExpected(rowAddr[r], rowData[r]);
        end
        haltAddr = (rowCount - 1) * 4;
    endtask

    task automatic printCounts();
        $display("stores seen %0d of %0d expected, errors %0d",
                 storeCheck.storeCount, storeCheck.expCount, storeCheck.errorCount);
    endtask

    // memory, ack after 0 to 3 idle cycles
    always @(posedge clk)
    begin
        if (memAck)
        begin
            if (!memReq)
                memAck <= 1'b0;
        end
        else if (memReq)
        begin
            if (!waitActive)
            begin
                lfsr       = lfsrStep(lfsr);
                lfsr       = lfsrStep(lfsr);
                waitLeft   = lfsr[1:0];
                waitActive = 1'b1;
            end
            if (waitLeft == 2'd0)
            begin
                waitActive = 1'b0;
                memAck <= 1'b1;
                if (memWe)
                    mem[memAddr[9:2]] <= memWdata;
                else
                    memRdata <= mem[memAddr[9:2]];
            end
            else
                waitLeft = waitLeft - 2'd1;
        end
    end

    always @(posedge clk)
    begin
        if (arstN && memReq && memAck && !memWe && memAddr == haltAddr)
            haltFetches <= haltFetches + 1;
    end

    initial
    begin
        arstN       = 1'b0;
        memAck      = 1'b0;
        memRdata    = '0;
        lfsr        = 32'h40f3;
        waitLeft    = 2'd0;
        waitActive  = 1'b0;
        rowCount    = 0;
        haltFetches = 0;
        buildProgram();
        loadProgram();
        repeat (resetCycles) @(posedge clk);
        arstN <= 1'b1;
        while (haltFetches < 2) // second fetch proves the self jump
            @(posedge clk);
        storeCheck.checkMissing();
        printCounts();
        if (storeCheck.errorCount == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    initial
    begin
        #1;
        limitCycles = rowCount * 12 * (maxDelay + 1) + resetCycles;
        repeat (limitCycles) @(posedge clk);
        $display("timeout: the core did not reach its final jump within %0d cycles",
                 limitCycles);
        printCounts();
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/rvChecker.sv
//####################
// store checker
// compares each memory write with the expected-store list
// and watches the req/ack rules around reset
//####################
`timescale 1ns/1ps
`default_nettype none

module rvChecker #(
    parameter int maxStores = 64
) (
    input  logic        clk,
    input  logic        arstN,
    input  logic        memReq,
    input  logic        memWe,
    input  logic        memAck,
    input  logic [31:0] memAddr,
    input  logic [31:0] memWdata
);

    logic [31:0] expAddr [0:maxStores-1];
    logic [31:0] expData [0:maxStores-1];
    int          expCount   = 0;
    int          storeCount = 0; // every write seen, extras too
    int          errorCount = 0;
    logic        ackPrev    = 1'b0;
    logic        reqPrev    = 1'b0;
    logic        arstPrev   = 1'b0;

    task automatic addExpected(input logic [31:0] addr, input logic [31:0] data);
        expAddr[expCount] = addr;
        expData[expCount] = data;
        expCount++;
    endtask

    task automatic checkStore();
        if (storeCount >= expCount)
        begin
            errorCount++;
            $display("%0t: unexpected store of %h to address %h", $time, memWdata, memAddr);
        end
        else
        begin
            if (memAddr !== expAddr[storeCount])
            begin
                errorCount++;
                $display("[FAIL] %0t memAddr expected %h actual %h",
                         $time, expAddr[storeCount], memAddr);
            end
            if (memWdata !== expData[storeCount])
            begin
                errorCount++;
                $display("[FAIL] %0t memWdata expected %h actual %h",
                         $time, expData[storeCount], memWdata);
            end
        end
        storeCount++;
    endtask

    task automatic checkMissing();
        if (storeCount < expCount)
        begin
            errorCount++;
            $display("only %0d of %0d expected stores were seen", storeCount, expCount);
        end
    endtask

    always @(posedge clk)
    begin
        if ((!arstN || !arstPrev) && (memReq || memWe))
        begin
            errorCount++;
            $display("%0t: memory request or write during or right after reset", $time);
        end
        if (memReq && !reqPrev && memAck)
        begin
            errorCount++;
            $display("%0t: new request raised while memAck was still high", $time);
        end
        if (memReq && memWe && memAck && !ackPrev) // one write handshake
            checkStore();
        ackPrev  <= memAck;
        reqPrev  <= memReq;
        arstPrev <= arstN;
    end

endmodule

`default_nettype wire

//--- logic/rvMultiCycle.sv
//####################
// rv32i multicycle core
// control unit and datapath on one req/ack memory port
//####################
`timescale 1ns/1ps
`default_nettype none

module rvMultiCycle #(
    parameter logic [rvCorePkg::xlen-1:0] resetPc = '0
) (
    input  logic                        clk,
    input  logic                        arstN,
    output logic                        memReq,
    output logic                        memWe,
    output logic [rvCorePkg::xlen-1:0]  memAddr,
    output logic [rvCorePkg::xlen-1:0]  memWdata,
    input  logic                        memAck,
    input  logic [rvCorePkg::xlen-1:0]  memRdata
);
    import rvCorePkg::*;

    logic      pcWrite;
    logic      branch;
    logic      branchNe;
    logic      iorD;
    logic      irWrite;
    logic      mdrWrite;
    logic      regWrite;
    srcAT      srcA;
    srcBT      srcB;
    aluOpT     aluOp;
    resultSrcT resultSrc;
    immSelT    immSel;
    opcodeT    opcode;
    logic [2:0] func3;

    controlUnit uControl (
        .clk       (clk),
        .arstN     (arstN),
        .opcode    (opcode),
        .func3     (func3),
        .memAck    (memAck),
        .memReq    (memReq),
        .memWe     (memWe),
        .pcWrite   (pcWrite),
        .branch    (branch),
        .branchNe  (branchNe),
        .iorD      (iorD),
        .irWrite   (irWrite),
        .mdrWrite  (mdrWrite),
        .regWrite  (regWrite),
        .srcA      (srcA),
        .srcB      (srcB),
        .aluOp     (aluOp),
        .resultSrc (resultSrc),
        .immSel    (immSel)
    );

    datapath #(
        .resetPc (resetPc)
    ) uDatapath (
        .clk       (clk),
        .arstN     (arstN),
        .pcWrite   (pcWrite),
        .branch    (branch),
        .branchNe  (branchNe),
        .iorD      (iorD),
        .irWrite   (irWrite),
        .mdrWrite  (mdrWrite),
        .regWrite  (regWrite),
        .srcA      (srcA),
        .srcB      (srcB),
        .aluOp     (aluOp),
        .resultSrc (resultSrc),
        .immSel    (immSel),
        .memRdata  (memRdata),
        .memAddr   (memAddr),
        .memWdata  (memWdata),
        .opcode    (opcode),
        .func3     (func3),
        .func7b5   () // alu decodes it inside the datapath
    );

endmodule

`default_nettype wire

//--- logic/datapath.sv
//####################
// multicycle datapath
// pc, ir, mdr, a/b/aluOut registers and source muxes
//####################
`timescale 1ns/1ps
`default_nettype none

module datapath #(
    parameter logic [rvCorePkg::xlen-1:0] resetPc = '0
) (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic                        pcWrite,
    input  logic                        branch,
    input  logic                        branchNe,
    input  logic                        iorD,
    input  logic                        irWrite,
    input  logic                        mdrWrite,
    input  logic                        regWrite,
    input  rvCorePkg::srcAT             srcA,
    input  rvCorePkg::srcBT             srcB,
    input  rvCorePkg::aluOpT            aluOp,
    input  rvCorePkg::resultSrcT        resultSrc,
    input  rvCorePkg::immSelT           immSel,
    input  logic [rvCorePkg::xlen-1:0]  memRdata,
    output logic [rvCorePkg::xlen-1:0]  memAddr,
    output logic [rvCorePkg::xlen-1:0]  memWdata,
    output rvCorePkg::opcodeT           opcode,
    output logic [2:0]                  func3,
    output logic                        func7b5
);
    import rvCorePkg::*;

    logic [xlen-1:0] pcReg;
    logic [xlen-1:0] oldPcReg;
    instrWordT       ir;
    logic [xlen-1:0] mdrReg;
    logic [xlen-1:0] aReg;
    logic [xlen-1:0] bReg;
    logic [xlen-1:0] aluOutReg;
    logic [xlen-1:0] rdata1;
    logic [xlen-1:0] rdata2;
    logic [xlen-1:0] immVal;
    logic [xlen-1:0] aluA;
    logic [xlen-1:0] aluB;
    logic [xlen-1:0] aluY;
    logic [xlen-1:0] result;
    logic            zero;
    logic            takeBranch;

    assign takeBranch = branch && (zero ^ branchNe);

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            pcReg <= resetPc;
        else if (pcWrite || takeBranch)
            pcReg <= {result[xlen-1:1], 1'b0}; // bit 0 cleared for jalr
    end

    always_ff @(posedge clk)
    begin
        if (irWrite)
        begin
            ir       <= memRdata;
            oldPcReg <= pcReg; // address of this instruction
        end
        if (mdrWrite)
            mdrReg <= memRdata;
        aReg      <= rdata1;
        bReg      <= rdata2;
        aluOutReg <= aluY;
    end

    always_comb
    begin
        case (srcA)
            oldPc:   aluA = oldPcReg;
            regA:    aluA = aReg;
            default: aluA = pcReg;
        endcase
        case (srcB)
            regB:    aluB = bReg;
            imm:     aluB = immVal;
            default: aluB = xlen'(4);
        endcase
        case (resultSrc)
            memData:   result = mdrReg;
            aluResult: result = aluY;
            default:   result = aluOutReg;
        endcase
    end

    assign memAddr  = iorD ? aluOutReg : pcReg;
    assign memWdata = bReg;
    assign opcode   = opcodeT'(ir.r.opcode);
    assign func3    = ir.r.func3;
    assign func7b5  = ir.r.func7[5];

    regFile uRegFile (
        .clk    (clk),
        .arstN  (arstN),
        .rs1    (ir.r.rs1),
        .rs2    (ir.r.rs2),
        .rd     (ir.r.rd),
        .we     (regWrite),
        .wdata  (result),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    immGen uImmGen (
        .instr  (ir),
        .immSel (immSel),
        .imm    (immVal)
    );

    alu uAlu (
        .aluOp   (aluOp),
        .func3   (ir.r.func3),
        .func7b5 (ir.r.func7[5]),
        .opIsReg (ir.r.opcode == rType),
        .a       (aluA),
        .b       (aluB),
        .result  (aluY),
        .zero    (zero)
    );

endmodule

`default_nettype wire

//--- logic/controlUnit.sv
//####################
// multicycle control unit
// state machine, control decoding and the memory req/ack handshake
//####################
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  logic                  clk,
    input  logic                  arstN,
    input  rvCorePkg::opcodeT     opcode,
    input  logic [2:0]            func3,
    input  logic                  memAck,
    output logic                  memReq,
    output logic                  memWe,
    output logic                  pcWrite,
    output logic                  branch,
    output logic                  branchNe,
    output logic                  iorD,
    output logic                  irWrite,
    output logic                  mdrWrite,
    output logic                  regWrite,
    output rvCorePkg::srcAT       srcA,
    output rvCorePkg::srcBT       srcB,
    output rvCorePkg::aluOpT      aluOp,
    output rvCorePkg::resultSrcT  resultSrc,
    output rvCorePkg::immSelT     immSel
);
    import rvCorePkg::*;

    typedef enum logic [3:0] {
        sFetch, sFetchRelease, sDecode, sMemAddr, sMemAccess, sMemRelease,
        sMemWriteback, sExecuteR, sExecuteI, sAluWriteback, sBranch,
        sLui, sAuipc, sJal, sJalr
    } stateT;

    stateT state;
    stateT nextState;
    logic  isStore;

    assign isStore = (opcode == sType);

    // request and write enable come straight from flops
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            state  <= sFetch;
            memReq <= 1'b0;
            memWe  <= 1'b0;
        end
        else
        begin
            state  <= nextState;
            memReq <= (nextState == sFetch) || (nextState == sMemAccess);
            memWe  <= (nextState == sMemAccess) && isStore;
        end
    end

    always_comb
    begin
        nextState = state;
        pcWrite   = 1'b0;
        branch    = 1'b0;
        branchNe  = 1'b0;
        iorD      = 1'b0;
        irWrite   = 1'b0;
        mdrWrite  = 1'b0;
        regWrite  = 1'b0;
        srcA      = pc;
        srcB      = four;
        aluOp     = add;
        resultSrc = aluOut;
        immSel    = immI;
        case (state)
            sFetch:
            begin
                resultSrc = aluResult; // pc + 4
                if (memAck)
                begin
                    irWrite   = 1'b1;
                    pcWrite   = 1'b1;
                    nextState = sFetchRelease;
                end
            end
            sFetchRelease:
            begin
                if (!memAck)
                    nextState = sDecode;
            end
            sDecode:
            begin
                srcA   = oldPc;
                srcB   = imm;
                immSel = (opcode == jal) ? immJ : immB; // target into aluOut
                case (opcode)
                    load:    nextState = sMemAddr;
                    sType:   nextState = sMemAddr;
                    rType:   nextState = sExecuteR;
                    iType:   nextState = sExecuteI;
                    bType:   nextState = sBranch;
                    lui:     nextState = sLui;
                    auipc:   nextState = sAuipc;
                    jal:     nextState = sJal;
                    jalr:    nextState = sJalr;
                    default: nextState = sFetch; // unknown opcode, skip it
                endcase
            end
            sMemAddr, sMemAccess, sMemRelease:
            begin
                // address held in aluOut for the whole access
                srcA   = regA;
                srcB   = imm;
                immSel = isStore ? immS : immI;
                iorD   = 1'b1;
                if (state == sMemAddr)
                    nextState = sMemAccess;
                else if (state == sMemAccess && memAck)
                begin
                    mdrWrite  = 1'b1;
                    nextState = sMemRelease;
                end
                else if (state == sMemRelease && !memAck)
                    nextState = isStore ? sFetch : sMemWriteback;
            end
            sMemWriteback:
            begin
                resultSrc = memData;
                regWrite  = 1'b1;
                nextState = sFetch;
            end
            sExecuteR:
            begin
                srcA      = regA;
                srcB      = regB;
                aluOp     = func;
                nextState = sAluWriteback;
            end
            sExecuteI:
            begin
                srcA      = regA;
                srcB      = imm;
                aluOp     = func;
                nextState = sAluWriteback;
            end
            sAluWriteback:
            begin
                regWrite  = 1'b1;
                nextState = sFetch;
            end
            sBranch:
            begin
                srcA      = regA;
                srcB      = regB;
                aluOp     = sub;
                branch    = 1'b1;
                branchNe  = (func3 == 3'b001); // bne, else beq
                nextState = sFetch;
            end
            sLui:
            begin
                srcB      = imm;
                immSel    = immU;
                aluOp     = passB;
                nextState = sAluWriteback;
            end
            sAuipc:
            begin
                srcA      = oldPc;
                srcB      = imm;
                immSel    = immU;
                nextState = sAluWriteback;
            end
            sJalr:
            begin
                srcA      = regA;
                srcB      = imm;
                nextState = sJal; // then shares the jal path
            end
            sJal:
            begin
                pcWrite   = 1'b1; // target from aluOut
                srcA      = oldPc; // link = oldPc + 4
                nextState = sAluWriteback;
            end
            default:
            begin
                nextState = sFetch;
            end
        endcase
    end

    // a request is withdrawn only after the memory has answered it
    assert property (@(posedge clk) disable iff (!arstN)
        $fell(memReq) |-> $past(memAck));

    assert property (@(posedge clk) disable iff (!arstN)
        !(regWrite && memWe));

endmodule

`default_nettype wire

//--- logic/immGen.sv
//####################
// immediate generator
// sign-extended I/S/B/J and upper U immediates
//####################
`timescale 1ns/1ps
`default_nettype none

module immGen (
    input  rvCorePkg::instrWordT        instr,
    input  rvCorePkg::immSelT           immSel,
    output logic [rvCorePkg::xlen-1:0]  imm
);
    import rvCorePkg::*;

    always_comb
    begin
        case (immSel)
            immS:
                imm = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
            immB:
                imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                       instr.b.immHi, instr.b.immLo, 1'b0};
            immU:
                imm = {instr.u.imm, 12'b0}; // zeros below
            immJ:
                imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.immHi,
                       instr.j.imm11, instr.j.immLo, 1'b0};
            default:
                imm = {{20{instr.i.imm[11]}}, instr.i.imm};
        endcase
    end

endmodule

`default_nettype wire

//--- logic/regFile.sv
//####################
// register file, 32 x 32
// two async reads, one sync write, x0 reads zero
//####################
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic [4:0]                  rs1,
    input  logic [4:0]                  rs2,
    input  logic [4:0]                  rd,
    input  logic                        we,
    input  logic [rvCorePkg::xlen-1:0]  wdata,
    output logic [rvCorePkg::xlen-1:0]  rdata1,
    output logic [rvCorePkg::xlen-1:0]  rdata2
);
    import rvCorePkg::*;

    logic [xlen-1:0] regs [0:31];

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int k = 0; k < 32; k++)
                regs[k] <= '0;
        end
        else if (we && rd != '0) // x0 never written
            regs[rd] <= wdata;
    end

    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

    assert property (@(posedge clk) disable iff (!arstN)
        (rs1 == '0) |-> (rdata1 == '0));

    assert property (@(posedge clk) disable iff (!arstN)
        (rs2 == '0) |-> (rdata2 == '0));

endmodule

`default_nettype wire

//--- logic/alu.sv
//####################
// alu with its decoder
// add, sub, logic ops, slt and shifts
//####################
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  rvCorePkg::aluOpT            aluOp,
    input  logic [2:0]                  func3,
    input  logic                        func7b5,
    input  logic                        opIsReg,
    input  logic [rvCorePkg::xlen-1:0]  a,
    input  logic [rvCorePkg::xlen-1:0]  b,
    output logic [rvCorePkg::xlen-1:0]  result,
    output logic                        zero
);
    import rvCorePkg::*;

    logic [2:0]      op; // effective func3
    logic            subtract;
    logic [xlen-1:0] sum;

    always_comb
    begin
        op       = 3'b000;
        subtract = 1'b0;
        if (aluOp == sub)
            subtract = 1'b1;
        else if (aluOp == func)
        begin
            op       = func3;
            subtract = opIsReg && func7b5 && (func3 == 3'b000); // sub, never addi
        end
    end

    assign sum = subtract ? (a - b) : (a + b);

    always_comb
    begin
        if (aluOp == passB)
            result = b; // lui
        else
        begin
            case (op)
                3'b001:  result = a << b[4:0];
                3'b010:  result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
                3'b100:  result = a ^ b;
                3'b101:  result = a >> b[4:0]; // logical only
                3'b110:  result = a | b;
                3'b111:  result = a & b;
                default: result = sum;
            endcase
        end
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

//--- logic/rvCorePkg.sv
//####################
// rv32i core package
// opcodes, control encodings and the instruction word views
//####################
`default_nettype none

package rvCorePkg;

    localparam int xlen = 32;

    typedef enum logic [6:0] {
        rType = 7'b0110011,
        iType = 7'b0010011,
        sType = 7'b0100011,
        bType = 7'b1100011,
        lui   = 7'b0110111,
        auipc = 7'b0010111,
        jal   = 7'b1101111,
        jalr  = 7'b1100111,
        load  = 7'b0000011
    } opcodeT;

    // one fetched word, seen through each encoding format
    typedef union packed {
        struct packed {
            logic [6:0] func7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] func3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  func3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] func3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm12;
            logic [5:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] func3;
            logic [3:0] immLo;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm20;
            logic [9:0] immLo;
            logic       imm11;
            logic [7:0] immHi;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } instrWordT;

    typedef enum logic [1:0] {add, sub, func, passB} aluOpT;

    typedef enum logic [1:0] {pc, oldPc, regA} srcAT;

    typedef enum logic [1:0] {regB, imm, four} srcBT;

    typedef enum logic [1:0] {aluOut, memData, aluResult} resultSrcT;

    typedef enum logic [2:0] {immI, immS, immB, immU, immJ} immSelT;

endpackage

`default_nettype wire
